// ==== build.f ====
+incdir+hw
hw/cps_video_pkg.sv
hw/cps_bus_capture.sv
hw/cps_mmr.sv
hw/cps_pal_copy.sv
hw/cps_frame_latch.sv
hw/cps_video_regs.sv
tb/cps_video_regs_properties.sv
tb/cps_video_regs_checker.sv
tb/cps_video_regs_tb.sv

// ==== Bender.yml ====
package:
  name: cps_video_regs

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cps_video_pkg.sv
      - hw/cps_bus_capture.sv
      - hw/cps_mmr.sv
      - hw/cps_pal_copy.sv
      - hw/cps_frame_latch.sv
      - hw/cps_video_regs.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/cps_video_regs_properties.sv
      - tb/cps_video_regs_checker.sv
      - tb/cps_video_regs_tb.sv

// ==== tb/cps_video_regs_tb.sv ====
// Video register block testbench
`timescale 1ns/1ps
`default_nettype none

`include "cps_video_settings.svh"

module cps_video_regs_tb;

    localparam logic [1:0] BANK_NONE    = 2'd0;
    localparam logic [1:0] BANK_A       = 2'd1;
    localparam logic [1:0] BANK_B       = 2'd2;
    localparam int         COPY_TIMEOUT = 40;

    // Game map in layer, prio0 to prio3, page enable order
    localparam logic [4:0] MAP_ADDR [0:5] = '{5'h13, 5'h0a, 5'h0c, 5'h0e, 5'h10, 5'h18};

    typedef struct packed {
        logic [1:0]       bank;
        logic [4:0]       addr;
        logic [1:0]       dsn;
        logic [15:0]      data;
        logic             vb_after;
        logic [4:0]       fld;
        logic [15:0]      exp_val;
        logic             chk_rdata;
        logic [15:0]      exp_rdata;
        logic             chk_copy;
        logic [2:0]       exp_n;
        logic [0:5][15:0] exp_copy;
    } row_t;

    logic                       clk;
    logic                       reg_rst;
    logic                       cs_a;
    logic                       cs_b;
    logic [4:0]                 addr;
    logic [1:0]                 dsn;
    logic [15:0]                wdata;
    logic                       vblank;
    cps_video_pkg::cps_b_map_t  b_map;
    logic [15:0]                rdata;
    cps_video_pkg::cps_scroll_t scroll;
    cps_video_pkg::cps_layer_t  layer;
    logic                       copy_stb;
    logic [15:0]                copy_addr;
    logic                       copy_done;

    row_t        rows[$];
    string       names[$];
    // Reference model, words 0 to 17 are bank A and 18 to 23 bank B
    logic [15:0] live [0:23];
    logic [15:0] shown [0:23];
    logic [15:0] last_rdata;
    bit          timed_out;

    cps_video_regs dut0 (
        .clk(clk), .reg_rst(reg_rst), .cs_a(cs_a), .cs_b(cs_b), .addr(addr), .dsn(dsn),
        .wdata(wdata), .b_map(b_map), .vblank(vblank), .rdata(rdata), .scroll(scroll),
        .layer(layer), .copy_stb(copy_stb), .copy_addr(copy_addr), .copy_done(copy_done)
    );

    cps_video_regs_checker chk0 (
        .clk(clk), .scroll(scroll), .layer(layer), .rdata(rdata),
        .copy_stb(copy_stb), .copy_addr(copy_addr), .copy_done(copy_done)
    );

    bind cps_video_regs cps_video_regs_properties props0 (
        .clk(clk), .reg_rst(reg_rst), .vblank(vblank), .scroll(scroll),
        .copy_stb(copy_stb), .copy_done(copy_done)
    );

    always #4 clk = ~clk;

    // A low lane select lets that byte through
    function automatic logic [15:0] merge_lanes(input logic [15:0] old_word,
                                                input logic [15:0] new_word,
                                                input logic [1:0]  lanes);
        logic [15:0] mask;
        mask = {{8{~lanes[1]}}, {8{~lanes[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic void add_row(input string name, input logic [1:0] bank,
                                    input logic [4:0] a, input logic [1:0] lanes,
                                    input logic [15:0] value, input bit rnd, input bit vb,
                                    input logic [4:0] fld);
        row_t row;
        int   hits;
        int   slot;
        int   n;
        row          = '0;
        row.bank     = bank;
        row.addr     = a;
        row.dsn      = lanes;
        row.data     = rnd ? 16'($urandom) : value;
        row.vb_after = vb;
        row.fld      = fld;
        hits         = 0;
        slot         = 0;
        if (bank == BANK_A && a < 18) begin
            live[a] = merge_lanes(live[a], row.data, lanes);
        end
        if (bank == BANK_B) begin
            for (int i = 0; i < 6; i++) begin
                if (MAP_ADDR[i] == a) begin
                    hits++;
                    slot = 18 + i;
                end
            end
            // Unmapped address leaves registers and read data alone
            if (hits == 1) begin
                last_rdata = live[slot];
                live[slot] = merge_lanes(live[slot], row.data, lanes);
                if (slot == 23) begin
                    live[slot] = live[slot] & 16'h003f;
                end
            end
            row.chk_rdata = 1'b1;
            row.exp_rdata = last_rdata;
        end
        // Palette base write copies every enabled page in ascending order
        if (bank == BANK_A && a == 5'h05) begin
            row.chk_copy = 1'b1;
            n = 0;
            for (int p = 0; p < `CPS_PAL_PAGES; p++) begin
                if (live[23][p]) begin
                    row.exp_copy[n] = live[5] + 16'(p * `CPS_PAL_PAGE_WORDS);
                    n++;
                end
            end
            row.exp_n = 3'(n);
        end
        if (vb) begin
            shown = live;
        end
        row.exp_val = shown[fld];
        rows.push_back(row);
        names.push_back(name);
    endfunction

    function automatic void build_table();
        for (int i = 0; i < 24; i++) begin
            live[i] = (i >= 19 && i <= 22) ? 16'hffff : 16'h0000;
        end
        live[23]   = 16'h003f;
        shown      = live;
        last_rdata = 16'h0000;
        add_row("rst_hpos1",       BANK_NONE, 5'h00, 2'b11, 16'h0000, 0, 1, 5'd6);
        add_row("rst_ppu_ctrl",    BANK_NONE, 5'h00, 2'b11, 16'h0000, 0, 0, 5'd17);
        add_row("rst_prio0",       BANK_NONE, 5'h00, 2'b11, 16'h0000, 0, 0, 5'd19);
        add_row("rst_prio3",       BANK_NONE, 5'h00, 2'b11, 16'h0000, 0, 0, 5'd22);
        add_row("rst_page_en",     BANK_NONE, 5'h00, 2'b11, 16'h0000, 0, 0, 5'd23);
        add_row("hpos1_word",      BANK_A,    5'h06, 2'b00, 16'h1234, 0, 1, 5'd6);
        add_row("hpos1_upper",     BANK_A,    5'h06, 2'b01, 16'h0000, 1, 1, 5'd6);
        add_row("hpos1_lower",     BANK_A,    5'h06, 2'b10, 16'h0000, 1, 1, 5'd6);
        add_row("hpos1_no_lanes",  BANK_A,    5'h06, 2'b11, 16'h0000, 1, 1, 5'd6);
        add_row("vram1_word",      BANK_A,    5'h01, 2'b00, 16'h0000, 1, 1, 5'd1);
        add_row("vram1_lower",     BANK_A,    5'h01, 2'b10, 16'h0000, 1, 1, 5'd1);
        add_row("ppu_ctrl_word",   BANK_A,    5'h11, 2'b00, 16'h0000, 1, 1, 5'd17);
        add_row("ppu_ctrl_upper",  BANK_A,    5'h11, 2'b01, 16'h0000, 1, 1, 5'd17);
        add_row("hold_no_vblank",  BANK_A,    5'h06, 2'b00, 16'hbeef, 0, 0, 5'd6);
        add_row("latch_on_vblank", BANK_NONE, 5'h00, 2'b11, 16'h0000, 0, 1, 5'd6);
        add_row("b_layer",         BANK_B,    5'h13, 2'b00, 16'h0f3c, 0, 1, 5'd18);
        add_row("b_prio0",         BANK_B,    5'h0a, 2'b00, 16'h0000, 1, 1, 5'd19);
        add_row("b_prio1_lower",   BANK_B,    5'h0c, 2'b10, 16'h0000, 1, 1, 5'd20);
        add_row("b_prio2_upper",   BANK_B,    5'h0e, 2'b01, 16'h0000, 1, 1, 5'd21);
        add_row("b_prio3",         BANK_B,    5'h10, 2'b00, 16'h0000, 1, 1, 5'd22);
        add_row("b_layer_reread",  BANK_B,    5'h13, 2'b00, 16'ha5a5, 0, 1, 5'd18);
        add_row("b_unmapped",      BANK_B,    5'h02, 2'b00, 16'hffff, 0, 1, 5'd18);
        add_row("b_page_en",       BANK_B,    5'h18, 2'b00, 16'h002d, 0, 1, 5'd23);
        add_row("pal_copy_2d",     BANK_A,    5'h05, 2'b00, 16'h4000, 0, 1, 5'd5);
        add_row("b_page_off",      BANK_B,    5'h18, 2'b00, 16'h0000, 0, 1, 5'd23);
        add_row("pal_copy_empty",  BANK_A,    5'h05, 2'b00, 16'h7000, 0, 1, 5'd5);
    endfunction

    task automatic wait_copy_done(input string name, output bit ok);
        int n;
        n = 0;
        while (!copy_done && n < COPY_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        ok = copy_done;
        if (!ok) begin
            $display("%s: copy_done did not arrive within %0d cycles", name, COPY_TIMEOUT);
        end else begin
            // Checker counts the done pulse on the edge that ends it
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apply_row(input int r, output bit ok);
        row_t row;
        row = rows[r];
        ok  = 1'b1;
        chk0.clear_copies();
        cs_a  = (row.bank == BANK_A);
        cs_b  = (row.bank == BANK_B);
        addr  = row.addr;
        dsn   = row.dsn;
        wdata = row.data;
        @(posedge clk);
        #1;
        cs_a = 1'b0;
        cs_b = 1'b0;
        dsn  = 2'b11;
        // Register file takes the captured cycle on this edge
        @(posedge clk);
        #1;
        if (row.vb_after) begin
            vblank = 1'b1;
            @(posedge clk);
            #1;
            vblank = 1'b0;
        end
        if (row.chk_copy) begin
            wait_copy_done(names[r], ok);
        end
        if (ok) begin
            chk0.check_row(names[r], row.fld, row.exp_val, row.chk_rdata, row.exp_rdata,
                           row.chk_copy, row.exp_n, row.exp_copy);
        end
    endtask

    initial begin
        int seed_ret;
        int r;
        bit ok;
        seed_ret  = $urandom(33);
        clk       = 1'b0;
        reg_rst   = 1'b1;
        cs_a      = 1'b0;
        cs_b      = 1'b0;
        addr      = '0;
        dsn       = 2'b11;
        wdata     = '0;
        vblank    = 1'b0;
        b_map     = {MAP_ADDR[0], MAP_ADDR[1], MAP_ADDR[2], MAP_ADDR[3], MAP_ADDR[4],
                     MAP_ADDR[5]};
        timed_out = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        reg_rst = 1'b0;
        for (r = 0; r < rows.size() && !timed_out; r++) begin
            apply_row(r, ok);
            timed_out = !ok;
        end
        $display("tests %0d, ok %0d, failed %0d, assertion errors %0d",
                 chk0.pass_count + chk0.fail_count, chk0.pass_count, chk0.fail_count,
                 dut0.props0.err_count);
        if (chk0.fail_count == 0 && dut0.props0.err_count == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/cps_video_regs_checker.sv ====
// Video register result checker
`timescale 1ns/1ps
`default_nettype none

module cps_video_regs_checker (
    input  wire logic                  clk,
    input  cps_video_pkg::cps_scroll_t scroll,
    input  cps_video_pkg::cps_layer_t  layer,
    input  wire logic [15:0]           rdata,
    input  wire logic                  copy_stb,
    input  wire logic [15:0]           copy_addr,
    input  wire logic                  copy_done
);

    int          pass_count = 0;
    int          fail_count = 0;
    int          dones      = 0;
    logic [15:0] copies[$];

    // Copy address is valid in the same cycle as its strobe
    always @(posedge clk) begin
        if (copy_stb) begin
            copies.push_back(copy_addr);
        end
        if (copy_done) begin
            dones++;
        end
    end

    task automatic clear_copies();
        copies.delete();
        dones = 0;
    endtask

    // Scroll words in bus address order, then the bank B words
    function automatic logic [15:0] field_value(input logic [4:0] fld);
        logic [0:17][15:0] words;
        words = scroll;
        case (fld)
            5'd18:   return layer.layer_ctrl;
            5'd19:   return layer.prio0;
            5'd20:   return layer.prio1;
            5'd21:   return layer.prio2;
            5'd22:   return layer.prio3;
            5'd23:   return 16'(layer.pal_page_en);
            default: return (fld < 18) ? words[fld] : 16'h0000;
        endcase
    endfunction

    task automatic check_row(input string name, input logic [4:0] fld,
                             input logic [15:0] exp_val, input logic chk_rdata,
                             input logic [15:0] exp_rdata, input logic chk_copy,
                             input logic [2:0] exp_n, input logic [0:5][15:0] exp_copy);
        string msg;
        msg = "";
        if (field_value(fld) !== exp_val) begin
            msg = $sformatf("FAILED %s field expected 0x%04h actual 0x%04h",
                            name, exp_val, field_value(fld));
        end else if (chk_rdata && rdata !== exp_rdata) begin
            msg = $sformatf("FAILED %s rdata expected 0x%04h actual 0x%04h",
                            name, exp_rdata, rdata);
        end else if (!chk_copy && copies.size() != 0) begin
            msg = $sformatf("%s: copy strobes appeared without a palette base write", name);
        end else if (chk_copy && copies.size() != exp_n) begin
            msg = $sformatf("FAILED %s copy count expected %0d actual %0d",
                            name, exp_n, copies.size());
        end else if (chk_copy && dones != 1) begin
            msg = $sformatf("%s: copy_done pulsed %0d times instead of once", name, dones);
        end
        for (int i = 0; i < exp_n && chk_copy && msg == ""; i++) begin
            if (copies[i] !== exp_copy[i]) begin
                msg = $sformatf("FAILED %s copy %0d expected 0x%04h actual 0x%04h",
                                name, i, exp_copy[i], copies[i]);
            end
        end
        if (msg == "") begin
            pass_count++;
            $display("ok     %s", name);
        end else begin
            fail_count++;
            $display("%s", msg);
        end
    endtask

endmodule

`default_nettype wire

// ==== tb/cps_video_regs_properties.sv ====
// Video register block assertions
`timescale 1ns/1ps
`default_nettype none

module cps_video_regs_properties (
    input wire logic                 clk,
    input wire logic                 reg_rst,
    input wire logic                 vblank,
    input cps_video_pkg::cps_scroll_t scroll,
    input wire logic                 copy_stb,
    input wire logic                 copy_done
);

    int err_count = 0;

    // Done follows the last strobe, never shares its cycle
    stb_done_apart: assert property (@(posedge clk) disable iff (reg_rst)
        !(copy_stb && copy_done))
        else begin
            err_count++;
            $error("copy_stb and copy_done high in the same cycle");
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (reg_rst)
        copy_done |=> !copy_done)
        else begin
            err_count++;
            $error("copy_done held high for more than one cycle");
        end

    // Renderer side only moves after a vblank edge
    scroll_on_vblank: assert property (@(posedge clk) disable iff (reg_rst)
        $changed(scroll) |-> $past(vblank))
        else begin
            err_count++;
            $error("scroll changed without vblank on the previous edge");
        end

endmodule

`default_nettype wire

// ==== hw/cps_video_regs.sv ====
// Video register block top
`timescale 1ns/1ps
`default_nettype none

`include "cps_video_settings.svh"

module cps_video_regs (
    input  wire logic                      clk,
    input  wire logic                      reg_rst,
    input  wire logic                      cs_a,
    input  wire logic                      cs_b,
    input  wire logic [`CPS_ADDR_W-1:0]    addr,
    input  wire logic [1:0]                dsn,
    input  wire logic [`CPS_DATA_W-1:0]    wdata,
    input  cps_video_pkg::cps_b_map_t      b_map,
    input  wire logic                      vblank,
    output logic [`CPS_DATA_W-1:0]         rdata,
    output cps_video_pkg::cps_scroll_t     scroll,
    output cps_video_pkg::cps_layer_t      layer,
    output logic                           copy_stb,
    output logic [15:0]                    copy_addr,
    output logic                           copy_done
);

    cps_video_pkg::cps_bus_wr_t bus_wr;
    cps_video_pkg::cps_scroll_t mmr_scroll;
    cps_video_pkg::cps_layer_t  mmr_layer;
    logic                       pal_copy;

    cps_bus_capture u_capture (
        .clk     (clk),
        .reg_rst (reg_rst),
        .cs_a    (cs_a),
        .cs_b    (cs_b),
        .addr    (addr),
        .dsn     (dsn),
        .wdata   (wdata),
        .bus_wr  (bus_wr)
    );

    cps_mmr u_mmr (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .bus_wr   (bus_wr),
        .b_map    (b_map),
        .scroll   (mmr_scroll),
        .layer    (mmr_layer),
        .rdata    (rdata),
        .pal_copy (pal_copy)
    );

    // The copy works from live register values, not the frame copies
    cps_pal_copy u_pal_copy (
        .clk       (clk),
        .reg_rst   (reg_rst),
        .pal_copy  (pal_copy),
        .pal_base  (mmr_scroll.pal_base),
        .page_en   (mmr_layer.pal_page_en),
        .copy_stb  (copy_stb),
        .copy_addr (copy_addr),
        .copy_done (copy_done)
    );

    cps_frame_latch #(
        .payload_t (cps_video_pkg::cps_scroll_t),
        .RESET_VAL ('0)
    ) u_scroll_latch (
        .clk     (clk),
        .reg_rst (reg_rst),
        .vblank  (vblank),
        .d       (mmr_scroll),
        .q       (scroll)
    );

    cps_frame_latch #(
        .payload_t (cps_video_pkg::cps_layer_t),
        .RESET_VAL (cps_video_pkg::CPS_LAYER_RST)
    ) u_layer_latch (
        .clk     (clk),
        .reg_rst (reg_rst),
        .vblank  (vblank),
        .d       (mmr_layer),
        .q       (layer)
    );

endmodule

`default_nettype wire

// ==== hw/cps_frame_latch.sv ====
// Vblank frame latch
`timescale 1ns/1ps
`default_nettype none

module cps_frame_latch #(
    parameter type      payload_t = logic,
    parameter payload_t RESET_VAL = '0
) (
    input  wire logic clk,
    input  wire logic reg_rst,
    input  wire logic vblank,
    input  payload_t  d,
    output payload_t  q
);

    // Renderer sees one stable set of values for the whole frame
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            q <= RESET_VAL;
        end else if (vblank) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cps_pal_copy.sv ====
// Palette copy sequencer
`timescale 1ns/1ps
`default_nettype none

`include "cps_video_settings.svh"

module cps_pal_copy (
    input  wire logic                        clk,
    input  wire logic                        reg_rst,
    input  wire logic                        pal_copy,
    input  wire logic [15:0]                 pal_base,
    input  wire logic [`CPS_PAL_PAGES-1:0]   page_en,
    output logic                             copy_stb,
    output logic [15:0]                      copy_addr,
    output logic                             copy_done
);

    localparam int PAGE_W = $clog2(`CPS_PAL_PAGES);

    logic                      busy;
    // Pages still to visit, cleared one by one as they are emitted
    logic [`CPS_PAL_PAGES-1:0] pend;
    logic [15:0]               base_q;
    logic [PAGE_W-1:0]         next_page;
    logic [15:0]               page_offset;
    logic                      start;
    logic                      step;

    // Lowest pending page, disabled pages cost no cycle
    always_comb begin
        next_page = '0;
        for (int i = `CPS_PAL_PAGES - 1; i >= 0; i--) begin
            if (pend[i]) begin
                next_page = PAGE_W'(i);
            end
        end
    end

    assign page_offset = 16'(next_page) * 16'(`CPS_PAL_PAGE_WORDS);

    // Triggers during a running copy are dropped
    assign start = pal_copy && !busy;
    assign step  = busy && (pend != '0);

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            busy      <= 1'b0;
            pend      <= '0;
            copy_stb  <= 1'b0;
            copy_done <= 1'b0;
        end else begin
            copy_stb  <= 1'b0;
            copy_done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                pend <= page_en;
            end else if (step) begin
                copy_stb        <= 1'b1;
                pend[next_page] <= 1'b0;
            end else if (busy) begin
                // Nothing left, done follows the last strobe by one cycle
                copy_done <= 1'b1;
                busy      <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            base_q <= pal_base;
        end
        if (step) begin
            copy_addr <= base_q + page_offset;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cps_mmr.sv ====
// Video register file
`timescale 1ns/1ps
`default_nettype none

`include "cps_video_settings.svh"

module cps_mmr (
    input  wire logic                      clk,
    input  wire logic                      reg_rst,
    input  cps_video_pkg::cps_bus_wr_t     bus_wr,
    input  cps_video_pkg::cps_b_map_t      b_map,
    output cps_video_pkg::cps_scroll_t     scroll,
    output cps_video_pkg::cps_layer_t      layer,
    output logic [`CPS_DATA_W-1:0]         rdata,
    output logic                           pal_copy
);

    localparam logic [`CPS_ADDR_W-1:0] PAL_BASE_ADDR = `CPS_ADDR_W'(5'h05);

    // Bank A as words, element 0 lines up with the first scroll field
    logic [0:`CPS_A_REGS-1][`CPS_DATA_W-1:0] bank_a;
    cps_video_pkg::cps_layer_t               layer_q;

    logic                    a_hit;
    logic [`CPS_B_REGS-1:0]  b_hit;
    logic                    b_valid;
    logic [`CPS_DATA_W-1:0]  b_old;
    logic [`CPS_DATA_W-1:0]  b_new;
    logic                    arm;

    // Keep the old byte wherever its lane select is high
    function automatic logic [`CPS_DATA_W-1:0] merge(
        input logic [`CPS_DATA_W-1:0] old_data,
        input logic [`CPS_DATA_W-1:0] new_data,
        input logic [1:0]             dsn
    );
        merge = {dsn[1] ? old_data[15:8] : new_data[15:8],
                 dsn[0] ? old_data[7:0]  : new_data[7:0]};
    endfunction

    assign a_hit = bus_wr.addr < `CPS_ADDR_W'(`CPS_A_REGS);

    // Bank B decode, bit 0 is layer control and bit 5 the page enable
    assign b_hit = {bus_wr.addr == b_map.pal_page,
                    bus_wr.addr == b_map.prio3,
                    bus_wr.addr == b_map.prio2,
                    bus_wr.addr == b_map.prio1,
                    bus_wr.addr == b_map.prio0,
                    bus_wr.addr == b_map.layer};

    // A map with two entries on one address selects nothing
    assign b_valid = $onehot(b_hit);

    always_comb begin
        case (b_hit)
            6'b000001: b_old = layer_q.layer_ctrl;
            6'b000010: b_old = layer_q.prio0;
            6'b000100: b_old = layer_q.prio1;
            6'b001000: b_old = layer_q.prio2;
            6'b010000: b_old = layer_q.prio3;
            6'b100000: b_old = `CPS_DATA_W'(layer_q.pal_page_en);
            default:   b_old = '0;
        endcase
        b_new = merge(b_old, bus_wr.data, bus_wr.dsn);
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            bank_a   <= '0;
            layer_q  <= cps_video_pkg::CPS_LAYER_RST;
            rdata    <= '0;
            arm      <= 1'b0;
            pal_copy <= 1'b0;
        end else begin
            // Fire the copy only after the select drops so pal_base is final
            pal_copy <= 1'b0;
            if (!bus_wr.sel_a && arm) begin
                pal_copy <= 1'b1;
                arm      <= 1'b0;
            end

            if (bus_wr.sel_a && a_hit) begin
                bank_a[bus_wr.addr] <= merge(bank_a[bus_wr.addr], bus_wr.data, bus_wr.dsn);
                if (bus_wr.addr == PAL_BASE_ADDR) begin
                    arm <= 1'b1;
                end
            end

            if (bus_wr.sel_b && b_valid) begin
                // Read returns the value from before this write
                rdata <= b_old;
                case (b_hit)
                    6'b000001: layer_q.layer_ctrl  <= b_new;
                    6'b000010: layer_q.prio0       <= b_new;
                    6'b000100: layer_q.prio1       <= b_new;
                    6'b001000: layer_q.prio2       <= b_new;
                    6'b010000: layer_q.prio3       <= b_new;
                    6'b100000: layer_q.pal_page_en <= b_new[`CPS_PAL_PAGES-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign scroll = cps_video_pkg::cps_scroll_t'(bank_a);
    assign layer  = layer_q;

endmodule

`default_nettype wire

// ==== hw/cps_bus_capture.sv ====
// CPU bus capture
`timescale 1ns/1ps
`default_nettype none

`include "cps_video_settings.svh"

module cps_bus_capture (
    input  wire logic                      clk,
    input  wire logic                      reg_rst,
    input  wire logic                      cs_a,
    input  wire logic                      cs_b,
    input  wire logic [`CPS_ADDR_W-1:0]    addr,
    input  wire logic [1:0]                dsn,
    input  wire logic [`CPS_DATA_W-1:0]    wdata,
    output cps_video_pkg::cps_bus_wr_t     bus_wr
);

    // Chip selects qualify everything else
    logic                   sel_a_q;
    logic                   sel_b_q;

    // Address and data only matter while a select is high
    logic [`CPS_ADDR_W-1:0] addr_q;
    logic [1:0]             dsn_q;
    logic [`CPS_DATA_W-1:0] data_q;

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            sel_a_q <= 1'b0;
            sel_b_q <= 1'b0;
        end else begin
            sel_a_q <= cs_a;
            sel_b_q <= cs_b;
        end
    end

    // Same edge as the selects so the cycle stays coherent
    always_ff @(posedge clk) begin
        addr_q <= addr;
        dsn_q  <= dsn;
        data_q <= wdata;
    end

    always_comb begin
        bus_wr       = '0;
        bus_wr.sel_a = sel_a_q;
        bus_wr.sel_b = sel_b_q;
        bus_wr.addr  = addr_q;
        bus_wr.dsn   = dsn_q;
        bus_wr.data  = data_q;
    end

endmodule

`default_nettype wire

// ==== hw/cps_video_pkg.sv ====
// Video register types
`default_nettype none

`include "cps_video_settings.svh"

package cps_video_pkg;

    // One CPU bus cycle as seen on a clock edge
    typedef struct packed {
        logic                    sel_a;
        logic                    sel_b;
        logic [`CPS_ADDR_W-1:0]  addr;
        logic [1:0]              dsn;
        logic [`CPS_DATA_W-1:0]  data;
    } cps_bus_wr_t;

    // Bank A in address order, first field is register 0x00
    typedef struct packed {
        logic [15:0] vram_obj_base;
        logic [15:0] vram1_base;
        logic [15:0] vram2_base;
        logic [15:0] vram3_base;
        logic [15:0] vram_row_base;
        logic [15:0] pal_base;
        logic [15:0] hpos1;
        logic [15:0] vpos1;
        logic [15:0] hpos2;
        logic [15:0] vpos2;
        logic [15:0] hpos3;
        logic [15:0] vpos3;
        logic [15:0] hstar1;
        logic [15:0] vstar1;
        logic [15:0] hstar2;
        logic [15:0] vstar2;
        logic [15:0] vram_star_base;
        logic [15:0] ppu_ctrl;
    } cps_scroll_t;

    // Bank B contents
    typedef struct packed {
        logic [15:0]               layer_ctrl;
        logic [15:0]               prio0;
        logic [15:0]               prio1;
        logic [15:0]               prio2;
        logic [15:0]               prio3;
        logic [`CPS_PAL_PAGES-1:0] pal_page_en;
    } cps_layer_t;

    // Per game placement of the bank B registers
    typedef struct packed {
        logic [`CPS_ADDR_W-1:0] layer;
        logic [`CPS_ADDR_W-1:0] prio0;
        logic [`CPS_ADDR_W-1:0] prio1;
        logic [`CPS_ADDR_W-1:0] prio2;
        logic [`CPS_ADDR_W-1:0] prio3;
        logic [`CPS_ADDR_W-1:0] pal_page;
    } cps_b_map_t;

    // Priorities come up fully masked and every palette page enabled
    localparam cps_layer_t CPS_LAYER_RST = '{
        layer_ctrl:  16'h0000,
        prio0:       16'hffff,
        prio1:       16'hffff,
        prio2:       16'hffff,
        prio3:       16'hffff,
        pal_page_en: '1
    };

endpackage

`default_nettype wire

// ==== hw/cps_video_settings.svh ====
// Video register block settings

`ifndef CPS_VIDEO_SETTINGS_SVH
`define CPS_VIDEO_SETTINGS_SVH

// CPU word address width shared by both chip selects
`define CPS_ADDR_W 5

// CPU data bus width
`define CPS_DATA_W 16

// Bank A holds fixed registers 0x00 to 0x11
`define CPS_A_REGS 18

// Bank B holds layer control, four priority masks and the page enable
`define CPS_B_REGS 6

// Palette pages that a copy can visit
`define CPS_PAL_PAGES 6

// Words per palette page, the step between copy addresses
`define CPS_PAL_PAGE_WORDS 512

`endif
